/* files.f */
verilog/rvIsaPkg.sv
verilog/rvCtrlPkg.sv
verilog/instrDecoder.sv
verilog/aluUnit.sv
verilog/memoryHandler.sv
verilog/writebackRegFile.sv
verilog/cpuDatapath.sv
testbench/datapathAssertions.sv
testbench/datapathChecker.sv
testbench/cpuDatapathTb.sv

/* testbench/cpuDatapathTb.sv */
`default_nettype none

module cpuDatapathTb
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
();

    localparam int          NumRegs     = 32;
    localparam int          NumInstr    = 400;
    localparam int          SeedCount   = 20;            // ADDI / LUI warmup
    localparam int          ResetCycles = 3;
    localparam int          WaitLimit   = 50;            // cycles per wait loop
    localparam logic [31:0] Seed        = 32'h9b3d;
    localparam logic [31:0] LfsrTaps    = 32'h8020_0003; // x^32+x^22+x^2+x+1
    localparam logic [31:0] Nop         = 32'h0000_0013; // addi x0, x0, 0
    localparam logic [31:0] MemKey      = 32'h5a3c_96e1; // memory model pattern
    localparam logic [6:0]  BadOpcodes [8] = '{7'b0010111, 7'b1101111, 7'b1100111,
        7'b0001111, 7'b1110011, 7'b0000000, 7'b1111111, 7'b0101011};

    // expected response of one instruction
    typedef struct packed {
        logic [31:0] alu;
        logic        aluValid;
        logic        zero;
        logic        err;
        logic        taken;
        memReq_t     mem;
        logic        wr;      // register write expected
        logic [4:0]  rd;
        logic [31:0] wdata;
    } expect_t;

    logic        clk;
    logic        rst;
    logic [31:0] instruction;
    logic [31:0] dataFromMem;
    logic [31:0] aluResult;
    logic        zeroFlag, errFlag, branchTaken;
    memReq_t     memReq;
    logic [31:0] regWindow [NumRegs];
    logic [31:0] shadow [NumRegs];   // reference register file
    logic [31:0] lfsr;
    logic        checkEn;
    expect_t     exp;
    int          checks, errors, timeouts, assertFails, waited;

    cpuDatapath #(.NumRegs(NumRegs)) UUT (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .dataFromMem (dataFromMem),
        .aluResult   (aluResult),
        .zeroFlag    (zeroFlag),
        .errFlag     (errFlag),
        .branchTaken (branchTaken),
        .memReq      (memReq),
        .regWindow   (regWindow)
    );

    datapathChecker #(.NumRegs(NumRegs)) chk (
        .clk (clk), .enable (checkEn), .instruction (instruction),
        .aluResult (aluResult), .zeroFlag (zeroFlag), .errFlag (errFlag),
        .branchTaken (branchTaken), .memReq (memReq), .regWindow (regWindow),
        .expAlu (exp.alu), .expAluValid (exp.aluValid), .expZero (exp.zero),
        .expErr (exp.err), .expTaken (exp.taken), .expMem (exp.mem),
        .expRegs (shadow), .checks (checks), .errors (errors)
    );

    bind writebackRegFile datapathAssertions #(.NumRegs(NumRegs)) regAsserts (
        .clk (clk), .rst (rst), .fields (fields), .ctrl (ctrl), .regWindow (regWindow)
    );

    assign dataFromMem = memReq.addr ^ MemKey;   // read data fixed by address

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                shadow[i] <= 32'b0;
            end
        end else if (exp.wr) begin
            shadow[exp.rd] <= exp.wdata;
        end
    end

    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);   // right-shifting galois
    endfunction

    task automatic nextBits(input int n, output logic [31:0] v);
        v = 32'b0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsrStep(lfsr);
        end
    endtask

    function automatic logic [31:0] regVal(input logic [4:0] idx);
        if (idx == 5'd0 || idx >= NumRegs) begin
            return 32'b0;
        end
        return shadow[idx];
    endfunction

    function automatic logic regsCleared();
        for (int i = 0; i < NumRegs; i++) begin
            if (regWindow[i] !== 32'b0) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic makeInstr(input int idx, output logic [31:0] ins);
        logic [31:0] raw, cls, pick;
        nextBits(32, raw);   // base for regs and immediates
        nextBits(3, cls);
        nextBits(3, pick);
        if (idx < SeedCount) begin
            cls = idx[0] ? 32'd1 : 32'd5;   // LUI then ADDI
        end
        ins = raw;
        case (cls[2:0])
            3'd0: begin
                ins[6:0]   = OP;
                ins[31:25] = (raw[14:12] == 3'b000 || raw[14:12] == 3'b101) ?
                             {1'b0, raw[30], 5'b0} : 7'b0;   // sub / sra variant
            end
            3'd1: begin
                ins[6:0] = OP_IMM;
                if (idx < SeedCount) begin
                    ins[14:12] = 3'b000;   // ADDI
                end
            end
            3'd2: begin
                ins[6:0] = LOAD;
                if (ins[14:12] == 3'b011) begin
                    ins[14:12] = 3'b010;
                end
                if (ins[14:13] == 2'b11) begin
                    ins[13] = 1'b0;   // to LBU / LHU
                end
            end
            3'd3: begin
                ins[6:0] = STORE;
                ins[14]  = 1'b0;
                if (ins[13:12] == 2'b11) begin
                    ins[12] = 1'b0;
                end
            end
            3'd4: begin
                ins[6:0] = BRANCH;
                if (ins[14:13] == 2'b01) begin
                    ins[14] = 1'b1;   // reserved funct3 to BLTU / BGEU
                end
                if (pick[1:0] == 2'b00) begin
                    ins[24:20] = ins[19:15];   // equal operands now and then
                end
            end
            3'd5: ins[6:0] = LUI;
            3'd6: ins[6:0] = BadOpcodes[pick[2:0]];
            default: begin
                ins[6:0]   = OP;
                ins[31:25] = raw[31:25] | 7'h01;   // never 0 or 0100000
            end
        endcase
    endtask

    function automatic expect_t refModel(input logic [31:0] ins);
        expect_t     e;
        logic [31:0] a, b, immI, immS, addr, word;
        logic [7:0]  bt;
        logic [15:0] hw;
        logic [2:0]  f3;
        logic [1:0]  lane;
        logic        mis;
        e    = '0;
        f3   = ins[14:12];
        a    = regVal(ins[19:15]);
        b    = regVal(ins[24:20]);
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        e.rd = ins[11:7];
        case (ins[6:0])
            OP, OP_IMM: begin
                if (!ins[5]) begin
                    b = immI;   // OP_IMM
                end
                case (f3)
                    3'b000: e.alu = (ins[30] && ins[5]) ? a - b : a + b;
                    3'b001: e.alu = a << b[4:0];
                    3'b010: e.alu = {31'b0, $signed(a) < $signed(b)};
                    3'b011: e.alu = {31'b0, a < b};
                    3'b100: e.alu = a ^ b;
                    3'b101: begin
                        if (ins[30]) begin
                            e.alu = $signed(a) >>> b[4:0];
                        end else begin
                            e.alu = a >> b[4:0];
                        end
                    end
                    3'b110: e.alu = a | b;
                    default: e.alu = a & b;
                endcase
                e.err = ins[5] && !(ins[31:25] == 7'h00 ||
                        (ins[31:25] == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)));
                e.aluValid = !e.err;
                e.wr       = !e.err;
                e.wdata    = e.alu;
            end
            LOAD, STORE: begin
                addr  = a + (ins[5] ? immS : immI);
                lane  = addr[1:0];
                mis   = (f3[1:0] == 2'b01 && lane[0]) || (f3[1:0] == 2'b10 && lane != 2'b00);
                e.alu = addr;
                e.aluValid   = 1'b1;
                e.mem.addr   = {addr[31:2], 2'b00};
                e.mem.read   = !ins[5] && !mis;
                e.mem.write  = ins[5] && !mis;
                if (!mis) begin
                    case (f3[1:0])
                        2'b00:   e.mem.byteEn = 4'b0001 << lane;
                        2'b01:   e.mem.byteEn = lane[1] ? 4'b1100 : 4'b0011;
                        default: e.mem.byteEn = 4'b1111;
                    endcase
                end
                case (f3[1:0])
                    2'b00:   e.mem.wdata = {4{b[7:0]}};
                    2'b01:   e.mem.wdata = {2{b[15:0]}};
                    default: e.mem.wdata = b;
                endcase
                word = e.mem.addr ^ MemKey;   // what the memory model returns
                bt   = word[8 * lane +: 8];
                hw   = word[16 * lane[1] +: 16];
                case (f3)
                    3'b000:  e.wdata = {{24{bt[7]}}, bt};
                    3'b001:  e.wdata = {{16{hw[15]}}, hw};
                    3'b100:  e.wdata = {24'b0, bt};
                    3'b101:  e.wdata = {16'b0, hw};
                    default: e.wdata = word;
                endcase
                e.wr = !ins[5] && !mis;
            end
            BRANCH: begin
                case (f3)
                    3'b000:  e.taken = a == b;
                    3'b001:  e.taken = a != b;
                    3'b100:  e.taken = $signed(a) < $signed(b);
                    3'b101:  e.taken = $signed(a) >= $signed(b);
                    3'b110:  e.taken = a < b;
                    default: e.taken = a >= b;
                endcase
            end
            LUI: begin
                e.wr    = 1'b1;
                e.wdata = {ins[31:12], 12'b0};
            end
            default: e.err = 1'b1;   // no write and no memory access
        endcase
        e.wr   = e.wr && e.rd != 5'd0 && e.rd < NumRegs;
        e.zero = e.alu == 32'b0;
        return e;
    endfunction

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        instruction = Nop;   // keeps memReq idle in reset
        checkEn     = 1'b0;
        lfsr        = Seed;
        timeouts    = 0;
        exp         = refModel(Nop);
        for (int n = 0; n < ResetCycles; n++) begin
            @(posedge clk);
        end
        @(negedge clk);
        rst    = 1'b0;
        waited = 0;
        while (!regsCleared() && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (!regsCleared()) begin
            $display("register file did not read all zero after reset");
            timeouts++;
        end else begin
            checkEn = 1'b1;
            for (int i = 0; i < NumInstr; i++) begin
                makeInstr(i, instruction);
                exp = refModel(instruction);
                @(negedge clk);
            end
            instruction = Nop;   // trailing NOP is checked too
            exp         = refModel(Nop);
            waited      = 0;
            while (checks < NumInstr + 1 && waited < WaitLimit) begin
                @(negedge clk);
                waited++;
            end
            if (checks < NumInstr + 1) begin
                $display("timeout: checker finished %0d of %0d instructions",
                         checks, NumInstr + 1);
                timeouts++;
            end
        end
        assertFails = UUT.regs.regAsserts.failCount;
        $display("checked %0d, value errors %0d, assertion failures %0d, timeouts %0d",
                 checks, errors, assertFails, timeouts);
        if (errors == 0 && assertFails == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/datapathChecker.sv */
`default_nettype none

module datapathChecker
    import rvCtrlPkg::*;
#(
    parameter int NumRegs = 32
) (
    input  logic        clk,
    input  logic        enable,        // high once reset is done
    input  logic [31:0] instruction,   // for error lines only
    input  logic [31:0] aluResult,
    input  logic        zeroFlag,
    input  logic        errFlag,
    input  logic        branchTaken,
    input  memReq_t     memReq,
    input  logic [31:0] regWindow [NumRegs],
    input  logic [31:0] expAlu,
    input  logic        expAluValid,   // alu value defined for this class
    input  logic        expZero,
    input  logic        expErr,
    input  logic        expTaken,
    input  memReq_t     expMem,
    input  logic [31:0] expRegs [NumRegs],
    output int          checks,        // instructions fully checked
    output int          errors
);

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h, instr %h",
                     $time, what, got, want, instruction);
        end
    endtask

    initial begin
        checks = 0;
        errors = 0;
    end

    always @(negedge clk) begin
        #15;   // 5 units before the rising edge, all comb outputs settled
        if (enable) begin
            if (expAluValid) begin
                compare("aluResult", aluResult, expAlu);
                compare("zeroFlag", 32'(zeroFlag), 32'(expZero));
            end
            compare("errFlag", 32'(errFlag), 32'(expErr));
            compare("branchTaken", 32'(branchTaken), 32'(expTaken));
            compare("memReq.read", 32'(memReq.read), 32'(expMem.read));
            compare("memReq.write", 32'(memReq.write), 32'(expMem.write));
            compare("memReq.byteEn", 32'(memReq.byteEn), 32'(expMem.byteEn));
            if (expMem.read || expMem.write) begin
                compare("memReq.addr", memReq.addr, expMem.addr);
            end
            if (expMem.write) begin
                compare("memReq.wdata", memReq.wdata, expMem.wdata);
            end
        end
        #10;   // just past the edge, write has landed
        if (enable) begin
            for (int i = 0; i < NumRegs; i++) begin
                compare($sformatf("x%0d", i), regWindow[i], expRegs[i]);
            end
            checks++;
        end
    end

endmodule

`default_nettype wire

/* testbench/datapathAssertions.sv */
`default_nettype none

module datapathAssertions
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
#(
    parameter int NumRegs = 32
) (
    input logic          clk,
    input logic          rst,
    input decodedInstr_t fields,
    input ctrl_t         ctrl,
    input logic [31:0]   regWindow [NumRegs]
);

    int   failCount = 0;   // summed into the final verdict
    logic anyNonZero;      // some register holds a value

    always_comb begin
        anyNonZero = 1'b0;
        for (int i = 0; i < NumRegs; i++) begin
            anyNonZero = anyNonZero | (regWindow[i] != 32'b0);
        end
    end

    // a write aimed at x0 leaves it zero
    x0Fixed: assert property (@(posedge clk)
            (ctrl.regWrite && fields.rd == 5'd0) |=> regWindow[0] == 32'b0)
        else begin
            $error("register x0 changed after a write to it");
            failCount++;
        end

    // reset edge clears everything, nothing written on top
    resetClears: assert property (@(posedge clk) rst |=> !anyNonZero)
        else begin
            $error("register file not all zero after a reset cycle");
            failCount++;
        end

    rwExclusive: assert property (@(posedge clk) !(ctrl.memRead && ctrl.memWrite))
        else begin
            $error("memory read and write requested together");
            failCount++;
        end

endmodule

`default_nettype wire

/* verilog/cpuDatapath.sv */
`default_nettype none

module cpuDatapath
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
#(
    parameter int NumRegs = 32
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] instruction,
    input  logic [31:0] dataFromMem,   // combinational read data
    output logic [31:0] aluResult,
    output logic        zeroFlag,
    output logic        errFlag,
    output logic        branchTaken,
    output memReq_t     memReq,
    output logic [31:0] regWindow [NumRegs]
);

    decodedInstr_t fields;
    ctrl_t         ctrl;
    logic [31:0]   imm;
    logic [31:0]   regA, regB;   // register read ports
    logic [31:0]   loadData;     // extended load value

    instrDecoder decoder (
        .instruction (instruction),
        .fields      (fields),
        .imm         (imm),
        .ctrl        (ctrl)
    );

    aluUnit alu (
        .ctrl        (ctrl),
        .funct7      (fields.funct7),
        .opA         (regA),
        .regB        (regB),
        .imm         (imm),
        .aluResult   (aluResult),
        .zeroFlag    (zeroFlag),
        .errFlag     (errFlag),
        .branchTaken (branchTaken)
    );

    memoryHandler mem (
        .ctrl        (ctrl),
        .funct3      (fields.funct3),
        .addr        (aluResult),   // alu sum is the address
        .storeData   (regB),
        .dataFromMem (dataFromMem),
        .memReq      (memReq),
        .loadData    (loadData)
    );

    writebackRegFile #(.NumRegs(NumRegs)) regs (
        .clk       (clk),
        .rst       (rst),
        .fields    (fields),
        .ctrl      (ctrl),
        .aluResult (aluResult),
        .loadData  (loadData),
        .imm       (imm),
        .regA      (regA),
        .regB      (regB),
        .regWindow (regWindow)
    );

endmodule

`default_nettype wire

/* verilog/writebackRegFile.sv */
`default_nettype none

module writebackRegFile
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
#(
    parameter int NumRegs = 32   // 32 for RV32I, 16 for RV32E
) (
    input  logic          clk,
    input  logic          rst,
    input  decodedInstr_t fields,
    input  ctrl_t         ctrl,
    input  logic [31:0]   aluResult,
    input  logic [31:0]   loadData,
    input  logic [31:0]   imm,
    output logic [31:0]   regA,
    output logic [31:0]   regB,
    output logic [31:0]   regWindow [NumRegs]
);

    logic [31:0] wbData;
    logic        wrEn;

    always_comb begin
        case (ctrl.wbSrc)
            WB_MEM:  wbData = loadData;
            WB_IMM:  wbData = imm;
            default: wbData = aluResult;
        endcase
    end

    // misaligned loads never reach memory, so they must not write either
    assign wrEn = ctrl.regWrite && !ctrl.illegal
               && !badFunct7(ctrl, fields.funct7)
               && !(ctrl.memRead && misaligned(fields.funct3, aluResult[1:0]))
               && fields.rd != 5'd0 && fields.rd < NumRegs;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                regWindow[i] <= 32'b0;
            end
        end else if (wrEn) begin
            regWindow[fields.rd] <= wbData;
        end
    end

    // x0 and out-of-range regs read zero
    assign regA = (fields.rs1 != 5'd0 && fields.rs1 < NumRegs) ? regWindow[fields.rs1] : 32'b0;
    assign regB = (fields.rs2 != 5'd0 && fields.rs2 < NumRegs) ? regWindow[fields.rs2] : 32'b0;

endmodule

`default_nettype wire

/* verilog/memoryHandler.sv */
`default_nettype none

module memoryHandler
    import rvCtrlPkg::*;
(
    input  ctrl_t       ctrl,
    input  logic [2:0]  funct3,
    input  logic [31:0] addr,
    input  logic [31:0] storeData,
    input  logic [31:0] dataFromMem,
    output memReq_t     memReq,
    output logic [31:0] loadData
);

    logic [1:0]  lane;      // byte offset in word
    logic        mis;
    logic [3:0]  laneEn;    // enables before request gating
    logic [31:0] shifted;   // selected lane moved to bit 0

    assign lane = addr[1:0];
    assign mis  = misaligned(funct3, lane);

    always_comb begin
        memReq.addr  = {addr[31:2], 2'b00};
        memReq.read  = ctrl.memRead & ~mis;    // drop misaligned access
        memReq.write = ctrl.memWrite & ~mis;
        case (funct3[1:0])
            2'b00: begin
                memReq.wdata = {4{storeData[7:0]}};
                laneEn       = 4'b0001 << lane;
            end
            2'b01: begin
                memReq.wdata = {2{storeData[15:0]}};
                laneEn       = 4'b0011 << {lane[1], 1'b0};
            end
            default: begin
                memReq.wdata = storeData;
                laneEn       = 4'b1111;
            end
        endcase
        memReq.byteEn = (memReq.read | memReq.write) ? laneEn : 4'b0000;
    end

    assign shifted = dataFromMem >> {lane, 3'b000};

    always_comb begin
        case (funct3)
            3'b000:  loadData = {{24{shifted[7]}}, shifted[7:0]};     // LB
            3'b001:  loadData = {{16{shifted[15]}}, shifted[15:0]};   // LH
            3'b100:  loadData = {24'b0, shifted[7:0]};                // LBU
            3'b101:  loadData = {16'b0, shifted[15:0]};               // LHU
            default: loadData = dataFromMem;                          // LW
        endcase
    end

endmodule

`default_nettype wire

/* verilog/aluUnit.sv */
`default_nettype none

module aluUnit
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  ctrl_t       ctrl,
    input  logic [6:0]  funct7,
    input  logic [31:0] opA,
    input  logic [31:0] regB,
    input  logic [31:0] imm,
    output logic [31:0] aluResult,
    output logic        zeroFlag,
    output logic        errFlag,
    output logic        branchTaken
);

    logic [31:0] opB;
    logic [31:0] sum, diff;
    logic [4:0]  shamt;
    logic        eq, lt, ltu;   // shared compare results
    logic        cond;          // branch condition before gating

    assign opB   = ctrl.aluSrc ? imm : regB;   // operand B mux
    assign sum   = opA + opB;
    assign diff  = opA - opB;
    assign shamt = opB[4:0];

    assign eq  = opA == opB;
    assign lt  = $signed(opA) < $signed(opB);
    assign ltu = opA < opB;

    always_comb begin
        case (ctrl.aluOp)
            ADD:     aluResult = sum;
            SUB:     aluResult = diff;
            SLL:     aluResult = opA << shamt;
            SLT:     aluResult = {31'b0, lt};
            SLTU:    aluResult = {31'b0, ltu};
            XOR:     aluResult = opA ^ opB;
            SRL:     aluResult = opA >> shamt;
            SRA:     aluResult = $signed(opA) >>> shamt;
            OR:      aluResult = opA | opB;
            AND:     aluResult = opA & opB;
            default: aluResult = diff;   // compares, zero on equal
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            BEQ:     cond = eq;
            BNE:     cond = !eq;
            BLT:     cond = lt;
            BGE:     cond = !lt;
            BLTU:    cond = ltu;
            BGEU:    cond = !ltu;
            default: cond = 1'b0;
        endcase
    end

    assign branchTaken = ctrl.branch & cond;
    assign zeroFlag    = aluResult == 32'b0;
    assign errFlag     = ctrl.illegal | badFunct7(ctrl, funct7);   // bad opcode or funct7

endmodule

`default_nettype wire

/* verilog/instrDecoder.sv */
`default_nettype none

module instrDecoder
    import rvIsaPkg::*;
    import rvCtrlPkg::*;
(
    input  logic [31:0]   instruction,
    output decodedInstr_t fields,
    output logic [31:0]   imm,
    output ctrl_t         ctrl
);

    logic [31:0] immI, immS, immB, immU;   // immediate per format
    logic        altBit;                   // inst[30], sub / arith shift
    logic        loadOk, storeOk, branchOk;
    aluOp_t      arithOp;                  // OP / OP_IMM operation
    aluOp_t      branchOp;                 // compare for BRANCH

    assign fields.rs1    = instruction[19:15];
    assign fields.rs2    = instruction[24:20];
    assign fields.rd     = instruction[11:7];
    assign fields.funct3 = instruction[14:12];
    assign fields.funct7 = instruction[31:25];
    assign fields.opcode = opcode_t'(instruction[6:0]);

    assign altBit = instruction[30];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
    assign immB = {{19{instruction[31]}}, instruction[31], instruction[7],
                   instruction[30:25], instruction[11:8], 1'b0};
    assign immU = {instruction[31:12], 12'b0};

    // LB LH LW LBU LHU / SB SH SW
    assign loadOk  = fields.funct3 != 3'b011 && fields.funct3[2:1] != 2'b11;
    assign storeOk = !fields.funct3[2] && fields.funct3[1:0] != 2'b11;

    always_comb begin
        case (fields.funct3)
            3'b000:  arithOp = (altBit && fields.opcode == OP) ? SUB : ADD;  // no SUBI
            3'b001:  arithOp = SLL;
            3'b010:  arithOp = SLT;
            3'b011:  arithOp = SLTU;
            3'b100:  arithOp = XOR;
            3'b101:  arithOp = altBit ? SRA : SRL;  // SRAI keeps bit 30 too
            3'b110:  arithOp = OR;
            default: arithOp = AND;
        endcase
    end

    always_comb begin
        branchOp = BEQ;
        branchOk = 1'b1;
        case (fields.funct3)
            3'b000:  branchOp = BEQ;
            3'b001:  branchOp = BNE;
            3'b100:  branchOp = BLT;
            3'b101:  branchOp = BGE;
            3'b110:  branchOp = BLTU;
            3'b111:  branchOp = BGEU;
            default: branchOk = 1'b0;   // 010 / 011 reserved
        endcase
    end

    always_comb begin
        ctrl = '0;   // WB_ALU, ADD, nothing enabled
        imm  = '0;
        case (fields.opcode)
            OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = arithOp;
            end
            OP_IMM: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = arithOp;
                imm           = immI;
            end
            LOAD: begin
                ctrl.aluSrc = 1'b1;   // address = rs1 + imm
                imm         = immI;
                if (loadOk) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.wbSrc    = WB_MEM;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            STORE: begin
                ctrl.aluSrc   = 1'b1;
                imm           = immS;
                ctrl.memWrite = storeOk;
                ctrl.illegal  = !storeOk;
            end
            BRANCH: begin
                imm          = immB;      // target offset, no pc here
                ctrl.aluOp   = branchOp;
                ctrl.branch  = branchOk;
                ctrl.illegal = !branchOk;
            end
            LUI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.wbSrc    = WB_IMM;
                imm           = immU;
            end
            default: ctrl.illegal = 1'b1;  // jal/jalr/auipc/fence/system/unknown
        endcase
    end

endmodule

`default_nettype wire

/* verilog/rvCtrlPkg.sv */
`default_nettype none

package rvCtrlPkg;
    import rvIsaPkg::*;

    // register write source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_IMM = 2'd2
    } wbSrc_t;

    typedef struct packed {
        logic   aluSrc;    // 1 = imm as operand B
        logic   regWrite;
        wbSrc_t wbSrc;
        logic   memRead;
        logic   memWrite;
        logic   branch;
        aluOp_t aluOp;
        logic   illegal;   // unsupported encoding
    } ctrl_t;

    // request to external data memory
    typedef struct packed {
        logic [31:0] addr;    // word aligned
        logic [31:0] wdata;   // lane replicated
        logic [3:0]  byteEn;
        logic        read;
        logic        write;
    } memReq_t;

    // half on odd byte or word off a word boundary
    function automatic logic misaligned(logic [2:0] funct3, logic [1:0] addrLow);
        case (funct3[1:0])
            2'b01:   return addrLow[0];
            2'b10:   return addrLow != 2'b00;
            default: return 1'b0;   // byte access, always aligned
        endcase
    endfunction

    // R-type only: funct7 must be zero, or 0100000 for SUB/SRA
    function automatic logic badFunct7(ctrl_t ctrl, logic [6:0] funct7);
        logic isOp;
        isOp = ctrl.regWrite && !ctrl.aluSrc && ctrl.wbSrc == WB_ALU;  // only OP matches
        return isOp && !(funct7 == 7'h00 ||
                         (funct7 == 7'h20 && (ctrl.aluOp == SUB || ctrl.aluOp == SRA)));
    endfunction

endpackage

`default_nettype wire

/* verilog/rvIsaPkg.sv */
`default_nettype none

package rvIsaPkg;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OP       = 7'b0110011,  // register-register ALU
        OP_IMM   = 7'b0010011,  // register-immediate ALU
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        BRANCH   = 7'b1100011,
        LUI      = 7'b0110111,
        // known to the ISA but not handled by this core, decoded as illegal
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        MISC_MEM = 7'b0001111,  // fence
        SYSTEM   = 7'b1110011   // ecall / ebreak / csr
    } opcode_t;

    // alu operation, compares sit above the arithmetic ops
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9,
        BEQ  = 4'd10,
        BNE  = 4'd11,
        BLT  = 4'd12,
        BGE  = 4'd13,
        BLTU = 4'd14,
        BGEU = 4'd15
    } aluOp_t;

    // raw instruction fields, 32 bits total
    typedef struct packed {
        logic [4:0] rs1;     // source reg 1
        logic [4:0] rs2;     // source reg 2
        logic [4:0] rd;      // dest reg
        logic [2:0] funct3;
        logic [6:0] funct7;
        opcode_t    opcode;
    } decodedInstr_t;

endpackage

`default_nettype wire
